// File: Bender.yml
package:
  name: rvfi_trace

sources:
  - rtl/rvfi_trace_pkg.sv
  - rtl/rvfi_insn_expander.sv
  - rtl/rvfi_retire_capture.sv
  - rtl/rvfi_trace_fifo.sv
  - rtl/rvfi_trace_serializer.sv
  - rtl/rvfi_trace_top.sv
  - target: test
    files:
      - tests/rvfi_trace_chk.sv
      - tests/tb_rvfi_trace.sv

// File: flist.f
rtl/rvfi_trace_pkg.sv
rtl/rvfi_insn_expander.sv
rtl/rvfi_retire_capture.sv
rtl/rvfi_trace_fifo.sv
rtl/rvfi_trace_serializer.sv
rtl/rvfi_trace_top.sv
tests/rvfi_trace_chk.sv
tests/tb_rvfi_trace.sv

// File: rtl/rvfi_insn_expander.sv
`timescale 1ns/1ps
`default_nettype none

module rvfi_insn_expander (
  input  wire logic [31:0]         insn,
  output rvfi_trace_pkg::insn_u    insn_exp,
  output logic                     compressed,
  output logic                     unsupported
);

  logic [15:0] c;
  logic [4:0]  c_rd;
  logic [4:0]  c_rs2;
  logic [4:0]  c_rdp;
  logic [4:0]  c_rs1p;
  logic [31:0] exp_word;

  assign c      = insn[15:0];
  assign c_rd   = c[11:7];
  assign c_rs2  = c[6:2];
  // Compressed register fields only reach x8..x15
  assign c_rdp  = {2'b01, c[4:2]};
  assign c_rs1p = {2'b01, c[9:7]};

  always_comb begin
    exp_word    = insn;
    compressed  = 1'b0;
    unsupported = 1'b0;
    if (insn[1:0] != 2'b11) begin
      compressed = 1'b1;
      exp_word   = '0;
      case ({insn[1:0], insn[15:13]})
        // C.LW -> lw rd', uimm(rs1')
        5'b00_010: begin
          exp_word = {5'b0, c[5], c[12:10], c[6], 2'b00, c_rs1p, 3'b010, c_rdp,
                      rvfi_trace_pkg::OPC_LOAD};
        end
        // C.SW -> sw rs2', uimm(rs1')
        5'b00_110: begin
          exp_word = {5'b0, c[5], c[12], c_rdp, c_rs1p, 3'b010, c[11:10], c[6], 2'b00,
                      rvfi_trace_pkg::OPC_STORE};
        end
        // C.ADDI -> addi rd, rd, imm
        5'b01_000: begin
          exp_word = {{6{c[12]}}, c[12], c[6:2], c_rd, 3'b000, c_rd,
                      rvfi_trace_pkg::OPC_OP_IMM};
        end
        // C.LI -> addi rd, x0, imm
        5'b01_010: begin
          exp_word = {{6{c[12]}}, c[12], c[6:2], 5'd0, 3'b000, c_rd,
                      rvfi_trace_pkg::OPC_OP_IMM};
        end
        5'b01_011: begin
          // rd == x2 is C.ADDI16SP, not in the supported subset
          if (c_rd != 5'd2) begin
            exp_word = {{14{c[12]}}, c[12], c[6:2], c_rd, rvfi_trace_pkg::OPC_LUI};
          end else begin
            unsupported = 1'b1;
          end
        end
        // C.J -> jal x0, offset
        5'b01_101: begin
          exp_word = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                      c[12], {8{c[12]}}, 5'd0, rvfi_trace_pkg::OPC_JAL};
        end
        // C.BEQZ -> beq rs1', x0, offset
        5'b01_110: begin
          exp_word = {c[12], {3{c[12]}}, c[6:5], c[2], 5'd0, c_rs1p, 3'b000,
                      c[11:10], c[4:3], c[12], rvfi_trace_pkg::OPC_BRANCH};
        end
        5'b10_100: begin
          // rs2 == x0 encodes C.JR, C.JALR and C.EBREAK
          if (c_rs2 == 5'd0) begin
            unsupported = 1'b1;
          end else if (c[12]) begin
            exp_word = {7'b0, c_rs2, c_rd, 3'b000, c_rd, rvfi_trace_pkg::OPC_OP};
          end else begin
            exp_word = {7'b0, c_rs2, 5'd0, 3'b000, c_rd, rvfi_trace_pkg::OPC_OP};
          end
        end
        default: begin
          unsupported = 1'b1;
        end
      endcase
    end
  end

  assign insn_exp = exp_word;

endmodule

`default_nettype wire

// File: rtl/rvfi_retire_capture.sv
`timescale 1ns/1ps
`default_nettype none

module rvfi_retire_capture (
  input  wire logic                   clk_i,
  input  wire logic                   reset,
  input  rvfi_trace_pkg::retire_t     retire,
  output logic                        push,
  output rvfi_trace_pkg::trace_rec_t  push_rec
);

  rvfi_trace_pkg::insn_u      insn_exp;
  rvfi_trace_pkg::trace_rec_t rec_d;
  logic                       is_compressed;
  logic                       is_unsupported;
  logic [31:0]                imm;
  logic [rvfi_trace_pkg::SEQ_W-1:0] seq_q;

  rvfi_insn_expander i_expander (
    .insn        (retire.insn),
    .insn_exp    (insn_exp),
    .compressed  (is_compressed),
    .unsupported (is_unsupported)
  );

  // Immediate decode from the expanded word, opcode and fields via union views
  always_comb begin
    imm = '0;
    if (!is_unsupported) begin
      case (insn_exp.r.opcode)
        rvfi_trace_pkg::OPC_OP_IMM,
        rvfi_trace_pkg::OPC_LOAD,
        rvfi_trace_pkg::OPC_JALR: begin
          imm = {{20{insn_exp.i.imm[11]}}, insn_exp.i.imm};
        end
        rvfi_trace_pkg::OPC_STORE: begin
          imm = {{20{insn_exp.s.imm_hi[6]}}, insn_exp.s.imm_hi, insn_exp.s.imm_lo};
        end
        rvfi_trace_pkg::OPC_BRANCH: begin
          // B layout reuses the S fields, imm_lo[0] carries bit 11
          imm = {{19{insn_exp.s.imm_hi[6]}}, insn_exp.s.imm_hi[6], insn_exp.s.imm_lo[0],
                 insn_exp.s.imm_hi[5:0], insn_exp.s.imm_lo[4:1], 1'b0};
        end
        rvfi_trace_pkg::OPC_LUI,
        rvfi_trace_pkg::OPC_AUIPC: begin
          imm = {insn_exp.u.imm, 12'b0};
        end
        rvfi_trace_pkg::OPC_JAL: begin
          imm = {{12{insn_exp.u.imm[19]}}, insn_exp.u.imm[7:0], insn_exp.u.imm[8],
                 insn_exp.u.imm[18:9], 1'b0};
        end
        default: begin
          imm = '0;
        end
      endcase
    end
  end

  always_comb begin
    rec_d            = '0;
    rec_d.seq        = seq_q;
    rec_d.compressed = is_compressed;
    rec_d.pc         = retire.pc;
    rec_d.insn       = insn_exp;
    rec_d.imm        = imm;
    rec_d.mem_addr   = retire.mem_addr;

    // FP register file wins when its valid flag is set
    if (retire.frd_wvalid) begin
      rec_d.rd       = {1'b1, retire.frd_addr};
      rec_d.rd_wdata = retire.frd_wdata;
    end else begin
      rec_d.rd       = {1'b0, retire.rd_addr};
      rec_d.rd_wdata = retire.rd_wdata;
    end
    rec_d.rs1 = retire.frs1_rvalid ? {1'b1, retire.frs1_addr} : {1'b0, retire.rs1_addr};
    rec_d.rs2 = retire.frs2_rvalid ? {1'b1, retire.frs2_addr} : {1'b0, retire.rs2_addr};

    if (retire.mem_wmask != '0) begin
      rec_d.mem_kind = rvfi_trace_pkg::MEM_WRITE;
      rec_d.mem_data = retire.mem_wdata;
    end else if (retire.mem_rmask != '0) begin
      rec_d.mem_kind = rvfi_trace_pkg::MEM_READ;
      rec_d.mem_data = retire.mem_rdata;
    end else begin
      rec_d.mem_kind = rvfi_trace_pkg::MEM_NONE;
      rec_d.mem_data = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      push  <= 1'b0;
      seq_q <= '0;
    end else begin
      push <= retire.valid;
      // Sequence advances even if the record is dropped later
      if (retire.valid) begin
        seq_q <= seq_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire.valid) begin
      push_rec <= rec_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/rvfi_trace_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rvfi_trace_fifo (
  input  wire logic                               clk_i,
  input  wire logic                               reset,
  input  wire logic                               push,
  input  rvfi_trace_pkg::trace_rec_t              push_rec,
  input  wire logic                               pop,
  output logic                                    not_empty,
  output rvfi_trace_pkg::trace_rec_t              head_rec,
  output logic [rvfi_trace_pkg::DROP_W-1:0]       drop_count
);

  rvfi_trace_pkg::trace_rec_t mem [rvfi_trace_pkg::TRACE_DEPTH];

  logic [rvfi_trace_pkg::TRACE_PTR_W-1:0] wr_ptr;
  logic [rvfi_trace_pkg::TRACE_PTR_W-1:0] rd_ptr;
  logic [rvfi_trace_pkg::TRACE_CNT_W-1:0] count;
  logic                                   full;
  logic                                   do_write;
  logic                                   do_read;

  assign full      = (count == rvfi_trace_pkg::TRACE_CNT_W'(rvfi_trace_pkg::TRACE_DEPTH));
  assign not_empty = (count != '0);
  // A full buffer drops the incoming record even if a pop frees a slot
  assign do_write  = push && !full;
  assign do_read   = pop && not_empty;
  assign head_rec  = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      mem[wr_ptr] <= push_rec;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      drop_count <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == rvfi_trace_pkg::TRACE_PTR_W'(rvfi_trace_pkg::TRACE_DEPTH - 1)) ?
                  '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == rvfi_trace_pkg::TRACE_PTR_W'(rvfi_trace_pkg::TRACE_DEPTH - 1)) ?
                  '0 : rd_ptr + 1'b1;
      end
      if (do_write && !do_read) begin
        count <= count + 1'b1;
      end else if (!do_write && do_read) begin
        count <= count - 1'b1;
      end
      // Saturating drop counter
      if (push && full && drop_count != '1) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/rvfi_trace_pkg.sv
`default_nettype none

package rvfi_trace_pkg;

  // Buffer and record geometry
  localparam int TRACE_DEPTH = 4;
  localparam int TRACE_WORDS = 7;
  localparam int SEQ_W       = 11;
  localparam int DROP_W      = 16;
  localparam int TRACE_PTR_W = $clog2(TRACE_DEPTH);
  localparam int TRACE_CNT_W = $clog2(TRACE_DEPTH + 1);
  localparam int WORD_IDX_W  = 3;

  // RV32 major opcodes used by the immediate decoder and the expander
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_READ  = 2'd1,
    MEM_WRITE = 2'd2
  } mem_kind_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } insn_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } insn_s_t;

  // Holds instruction bits 31..12 in imm
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } insn_u_t;

  typedef union packed {
    insn_r_t r;
    insn_i_t i;
    insn_s_t s;
    insn_u_t u;
  } insn_u;

  // Retirement report from the core, one strobe per retired instruction
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] insn;
    logic [4:0]  rd_addr;
    logic [31:0] rd_wdata;
    logic        frd_wvalid;
    logic [4:0]  frd_addr;
    logic [31:0] frd_wdata;
    logic [4:0]  rs1_addr;
    logic [31:0] rs1_rdata;
    logic        frs1_rvalid;
    logic [4:0]  frs1_addr;
    logic [31:0] frs1_rdata;
    logic [4:0]  rs2_addr;
    logic [31:0] rs2_rdata;
    logic        frs2_rvalid;
    logic [4:0]  frs2_addr;
    logic [31:0] frs2_rdata;
    logic [31:0] mem_addr;
    logic [31:0] mem_rmask;
    logic [31:0] mem_wmask;
    logic [31:0] mem_rdata;
    logic [31:0] mem_wdata;
  } retire_t;

  // Register numbers carry bit 5 set for the FP register file
  typedef struct packed {
    logic [SEQ_W-1:0] seq;
    logic             compressed;
    mem_kind_e        mem_kind;
    logic [5:0]       rd;
    logic [5:0]       rs1;
    logic [5:0]       rs2;
    logic [31:0]      pc;
    insn_u            insn;
    logic [31:0]      rd_wdata;
    logic [31:0]      imm;
    logic [31:0]      mem_addr;
    logic [31:0]      mem_data;
  } trace_rec_t;

endpackage

`default_nettype wire

// File: rtl/rvfi_trace_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module rvfi_trace_serializer (
  input  wire logic                                  clk_i,
  input  wire logic                                  reset,
  input  wire logic                                  not_empty,
  input  rvfi_trace_pkg::trace_rec_t                 head_rec,
  output logic                                       pop,
  input  wire logic                                  stall,
  output logic                                       word_valid,
  output logic [31:0]                                word,
  output logic [rvfi_trace_pkg::WORD_IDX_W-1:0]      word_index
);

  rvfi_trace_pkg::trace_rec_t              rec_q;
  logic                                    busy;
  logic [rvfi_trace_pkg::WORD_IDX_W-1:0]   idx;
  logic                                    last_word;
  logic                                    deliver;
  logic [31:0]                             header;

  assign last_word = (idx == rvfi_trace_pkg::WORD_IDX_W'(rvfi_trace_pkg::TRACE_WORDS - 1));
  assign deliver   = busy && !stall;
  // Load when idle, or back to back right after the last word goes out
  assign pop       = not_empty && (!busy || (deliver && last_word));

  assign header = {rec_q.compressed, rec_q.mem_kind, rec_q.rd, rec_q.rs1, rec_q.rs2,
                   rec_q.seq};

  always_comb begin
    case (idx)
      3'd0:    word = header;
      3'd1:    word = rec_q.pc;
      3'd2:    word = rec_q.insn;
      3'd3:    word = rec_q.rd_wdata;
      3'd4:    word = rec_q.imm;
      3'd5:    word = rec_q.mem_addr;
      3'd6:    word = rec_q.mem_data;
      default: word = '0;
    endcase
  end

  assign word_valid = busy;
  assign word_index = idx;

  always_ff @(posedge clk_i) begin
    if (reset) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (pop) begin
      busy <= 1'b1;
      idx  <= '0;
    end else if (deliver) begin
      if (last_word) begin
        busy <= 1'b0;
        idx  <= '0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      rec_q <= head_rec;
    end
  end

endmodule

`default_nettype wire

// File: rtl/rvfi_trace_top.sv
`timescale 1ns/1ps
`default_nettype none

module rvfi_trace_top (
  input  wire logic                                  clk_i,
  input  wire logic                                  reset,
  input  rvfi_trace_pkg::retire_t                    retire,
  input  wire logic                                  stall,
  output logic                                       word_valid,
  output logic [31:0]                                word,
  output logic [rvfi_trace_pkg::WORD_IDX_W-1:0]      word_index,
  output logic [rvfi_trace_pkg::DROP_W-1:0]          drop_count
);

  logic                       push;
  rvfi_trace_pkg::trace_rec_t push_rec;
  logic                       pop;
  logic                       not_empty;
  rvfi_trace_pkg::trace_rec_t head_rec;

  rvfi_retire_capture i_capture (
    .clk_i    (clk_i),
    .reset    (reset),
    .retire   (retire),
    .push     (push),
    .push_rec (push_rec)
  );

  rvfi_trace_fifo i_fifo (
    .clk_i      (clk_i),
    .reset      (reset),
    .push       (push),
    .push_rec   (push_rec),
    .pop        (pop),
    .not_empty  (not_empty),
    .head_rec   (head_rec),
    .drop_count (drop_count)
  );

  rvfi_trace_serializer i_serializer (
    .clk_i      (clk_i),
    .reset      (reset),
    .not_empty  (not_empty),
    .head_rec   (head_rec),
    .pop        (pop),
    .stall      (stall),
    .word_valid (word_valid),
    .word       (word),
    .word_index (word_index)
  );

endmodule

`default_nettype wire

// File: tests/rvfi_trace_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rvfi_trace_chk (
  input wire logic                                  clk_i,
  input wire logic                                  reset,
  input wire logic                                  stall,
  input wire logic                                  word_valid,
  input wire logic [31:0]                           word,
  input wire logic [rvfi_trace_pkg::WORD_IDX_W-1:0] word_index,
  input wire logic                                  push,
  input wire logic                                  pop
);

  logic [rvfi_trace_pkg::TRACE_CNT_W-1:0] occ;
  logic                                   accept;
  int                                     fail_count = 0;

  // Buffer occupancy rebuilt from push and pop
  // A push into a full buffer is lost
  assign accept = push && (occ != rvfi_trace_pkg::TRACE_CNT_W'(rvfi_trace_pkg::TRACE_DEPTH));

  always_ff @(posedge clk_i) begin
    if (reset) begin
      occ <= '0;
    end else begin
      occ <= occ + rvfi_trace_pkg::TRACE_CNT_W'(accept) - rvfi_trace_pkg::TRACE_CNT_W'(pop);
    end
  end

  // A stalled word stays on the port unchanged
  hold_on_stall: assert property (@(posedge clk_i) disable iff (reset)
    (word_valid && stall) |=> (word_valid && $stable(word) && $stable(word_index)))
    else begin
      $error("word or word_index changed while stalled");
      fail_count++;
    end

  index_in_range: assert property (@(posedge clk_i) disable iff (reset)
    word_index <= 3'd6)
    else begin
      $error("word_index went past the last word");
      fail_count++;
    end

  pop_needs_data: assert property (@(posedge clk_i) disable iff (reset)
    pop |-> (occ != '0))
    else begin
      $error("pop raised while the FIFO was empty");
      fail_count++;
    end

  quiet_after_reset: assert property (@(posedge clk_i)
    reset |=> !word_valid)
    else begin
      $error("word_valid high in the cycle after reset");
      fail_count++;
    end

endmodule

bind rvfi_trace_top rvfi_trace_chk i_rvfi_trace_chk (
  .clk_i      (clk_i),
  .reset      (reset),
  .stall      (stall),
  .word_valid (word_valid),
  .word       (word),
  .word_index (word_index),
  .push       (push),
  .pop        (pop)
);

`default_nettype wire

// File: tests/tb_rvfi_trace.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rvfi_trace;

  localparam int          WORDS     = rvfi_trace_pkg::TRACE_WORDS;
  localparam logic [31:0] RAND_SEED = 32'h3ed7;

  logic                                  clk_i;
  logic                                  reset;
  rvfi_trace_pkg::retire_t               retire;
  logic                                  stall;
  logic                                  word_valid;
  logic [31:0]                           word;
  logic [rvfi_trace_pkg::WORD_IDX_W-1:0] word_index;
  logic [rvfi_trace_pkg::DROP_W-1:0]     drop_count;

  // Each entry is {word_index, word}
  logic [34:0]                      exp_q[$];
  logic [34:0]                      want;
  logic [rvfi_trace_pkg::SEQ_W-1:0] seq_sw;
  int                               errors;
  int                               words_checked;
  int                               issued;
  int                               cycles;

  rvfi_trace_top i_rvfi_trace_top (
    .clk_i      (clk_i),
    .reset      (reset),
    .retire     (retire),
    .stall      (stall),
    .word_valid (word_valid),
    .word       (word),
    .word_index (word_index),
    .drop_count (drop_count)
  );

  always #2 clk_i = ~clk_i;

  // Limit grows with every retirement issued
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > 20 * WORDS * issued + 200) begin
      $display("Run timed out after %0d cycles, the trace stream stopped", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Immediate by instruction format, taken from the expanded word
  function automatic logic [31:0] ref_imm(input logic [31:0] w);
    case (w[6:0])
      7'h13, 7'h03, 7'h67: ref_imm = {{20{w[31]}}, w[31:20]};
      7'h23:               ref_imm = {{20{w[31]}}, w[31:25], w[11:7]};
      7'h63:               ref_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      7'h37, 7'h17:        ref_imm = {w[31:12], 12'h000};
      7'h6f:               ref_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default:             ref_imm = 32'h0;
    endcase
  endfunction

  function automatic void model_record(input rvfi_trace_pkg::retire_t r,
                                       input logic [31:0] exp_word,
                                       input logic [rvfi_trace_pkg::SEQ_W-1:0] seq);
    logic [5:0]  rd;
    logic [5:0]  rs1;
    logic [5:0]  rs2;
    logic [1:0]  kind;
    logic [31:0] data;
    logic [31:0] words [WORDS];
    rd  = r.frd_wvalid ? {1'b1, r.frd_addr} : {1'b0, r.rd_addr};
    rs1 = r.frs1_rvalid ? {1'b1, r.frs1_addr} : {1'b0, r.rs1_addr};
    rs2 = r.frs2_rvalid ? {1'b1, r.frs2_addr} : {1'b0, r.rs2_addr};
    if (r.mem_wmask != 32'h0) begin
      kind = rvfi_trace_pkg::MEM_WRITE;
      data = r.mem_wdata;
    end else if (r.mem_rmask != 32'h0) begin
      kind = rvfi_trace_pkg::MEM_READ;
      data = r.mem_rdata;
    end else begin
      kind = rvfi_trace_pkg::MEM_NONE;
      data = 32'h0;
    end
    words[0] = {(r.insn[1:0] != 2'b11), kind, rd, rs1, rs2, seq};
    words[1] = r.pc;
    words[2] = exp_word;
    words[3] = r.frd_wvalid ? r.frd_wdata : r.rd_wdata;
    words[4] = ref_imm(exp_word);
    words[5] = r.mem_addr;
    words[6] = data;
    for (int i = 0; i < WORDS; i++) begin
      exp_q.push_back({3'(i), words[i]});
    end
  endfunction

  function automatic rvfi_trace_pkg::retire_t make_retire(
    input logic [31:0] pc, input logic [31:0] insn, input logic [4:0] rd,
    input logic [31:0] rd_wdata, input logic [4:0] rs1, input logic [4:0] rs2);
    rvfi_trace_pkg::retire_t r;
    r          = '0;
    r.pc       = pc;
    r.insn     = insn;
    r.rd_addr  = rd;
    r.rd_wdata = rd_wdata;
    r.rs1_addr = rs1;
    r.rs2_addr = rs2;
    return r;
  endfunction

  function automatic rvfi_trace_pkg::retire_t random_retire();
    rvfi_trace_pkg::retire_t r;
    logic [31:0] w;
    logic [31:0] f;
    w = $urandom();
    f = $urandom();
    case ($urandom_range(0, 9))
      0: w[6:0] = 7'h13;
      1: w[6:0] = 7'h03;
      2: w[6:0] = 7'h67;
      3: w[6:0] = 7'h23;
      4: w[6:0] = 7'h63;
      5: w[6:0] = 7'h37;
      6: w[6:0] = 7'h17;
      7: w[6:0] = 7'h6f;
      8: w[6:0] = 7'h33;
      default: w[6:0] = 7'h53;
    endcase
    r             = make_retire($urandom(), w, f[4:0], $urandom(), f[9:5], f[14:10]);
    r.frd_addr    = f[19:15];
    r.frd_wvalid  = f[20];
    r.frd_wdata   = $urandom();
    r.frs1_rvalid = f[21];
    r.frs1_addr   = f[26:22];
    r.frs2_rvalid = f[27];
    r.frs2_addr   = w[11:7];
    r.mem_addr    = $urandom();
    r.mem_wmask   = f[28] ? 32'hF : 32'h0;
    r.mem_rmask   = f[29] ? 32'hF : 32'h0;
    r.mem_wdata   = $urandom();
    r.mem_rdata   = $urandom();
    return r;
  endfunction

  // One retirement strobe per call, back to back when called in a row
  task automatic retire_insn(input rvfi_trace_pkg::retire_t r, input logic [31:0] exp_word,
                             input bit expect_out);
    r.valid = 1'b1;
    @(posedge clk_i);
    retire <= r;
    if (expect_out) begin
      model_record(r, exp_word, seq_sw);
    end
    seq_sw = seq_sw + 1'b1;
    issued++;
  endtask

  task automatic wait_drain(input bit rand_stall);
    @(posedge clk_i);
    retire.valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      if (rand_stall) begin
        stall <= 1'($urandom_range(0, 1));
      end
    end
    @(posedge clk_i);
    stall <= 1'b0;
    // Idle cycles to catch any stray word
    repeat (2 * WORDS) @(posedge clk_i);
  endtask

  task automatic report_test(input string name);
    $display("%-11s finished: %0d words checked, %0d errors", name, words_checked, errors);
  endtask

  task automatic integer_retirements();
    rvfi_trace_pkg::retire_t r;
    r = make_retire(32'h0000_1000, 32'hFFD3_0293, 5'd5, 32'h0000_0041, 5'd6, 5'd0);
    retire_insn(r, r.insn, 1'b1);
    r = make_retire(32'h0000_1004, 32'h1234_53B7, 5'd7, 32'h1234_5000, 5'd0, 5'd0);
    retire_insn(r, r.insn, 1'b1);
    r = make_retire(32'h0000_1008, 32'hFF9F_F0EF, 5'd1, 32'h0000_100C, 5'd0, 5'd0);
    retire_insn(r, r.insn, 1'b1);
    r = make_retire(32'h0000_1000, 32'h0094_0663, 5'd0, 32'h0, 5'd8, 5'd9);
    retire_insn(r, r.insn, 1'b1);
    wait_drain(1'b0);
    report_test("integer");
  endtask

  task automatic memory_retirements();
    rvfi_trace_pkg::retire_t r;
    r           = make_retire(32'h0000_2000, 32'hFEA1_2E23, 5'd0, 32'h0, 5'd2, 5'd10);
    r.mem_addr  = 32'h8000_0FFC;
    r.mem_wmask = 32'hF;
    r.mem_wdata = 32'hDEAD_BEEF;
    retire_insn(r, r.insn, 1'b1);
    r           = make_retire(32'h0000_2004, 32'h0101_A583, 5'd11, 32'h1357_9BDF, 5'd3, 5'd0);
    r.mem_addr  = 32'h8000_0010;
    r.mem_rmask = 32'hF;
    r.mem_rdata = 32'h1357_9BDF;
    retire_insn(r, r.insn, 1'b1);
    wait_drain(1'b0);
    report_test("memory");
  endtask

  // Expanded words worked out by hand from the RVC encodings
  task automatic compressed_retirements();
    rvfi_trace_pkg::retire_t r;
    r = make_retire(32'h0000_3000, 32'h0000_1579, 5'd10, 32'h0000_0020, 5'd10, 5'd0);
    retire_insn(r, 32'hFFE5_0513, 1'b1);
    r           = make_retire(32'h0000_3002, 32'h0000_4584, 5'd9, 32'hCAFE_0001, 5'd11, 5'd0);
    r.mem_addr  = 32'h8000_0108;
    r.mem_rmask = 32'hF;
    r.mem_rdata = 32'hCAFE_0001;
    retire_insn(r, 32'h0085_A483, 1'b1);
    r = make_retire(32'h0000_3004, 32'h0000_A801, 5'd0, 32'h0, 5'd0, 5'd0);
    retire_insn(r, 32'h0100_006F, 1'b1);
    r = make_retire(32'h0000_3014, 32'h0000_8636, 5'd12, 32'h0000_0777, 5'd0, 5'd13);
    retire_insn(r, 32'h00D0_0633, 1'b1);
    // C.JR is outside the supported subset
    r = make_retire(32'h0000_3016, 32'h0000_8082, 5'd0, 32'h0, 5'd1, 5'd0);
    retire_insn(r, 32'h0, 1'b1);
    wait_drain(1'b0);
    report_test("compressed");
  endtask

  task automatic fp_registers();
    rvfi_trace_pkg::retire_t r;
    r             = make_retire(32'h0000_4000, 32'h0031_00D3, 5'd7, 32'h1111_1111, 5'd8, 5'd9);
    r.frd_wvalid  = 1'b1;
    r.frd_addr    = 5'd1;
    r.frd_wdata   = 32'h3F80_0000;
    r.frs1_rvalid = 1'b1;
    r.frs1_addr   = 5'd2;
    r.frs2_rvalid = 1'b1;
    r.frs2_addr   = 5'd3;
    retire_insn(r, r.insn, 1'b1);
    r            = make_retire(32'h0000_4004, 32'h0002_A207, 5'd0, 32'h2222_2222, 5'd5, 5'd0);
    r.frd_wvalid = 1'b1;
    r.frd_addr   = 5'd4;
    r.frd_wdata  = 32'h4049_0FDB;
    r.mem_addr   = 32'h8000_0200;
    r.mem_rmask  = 32'hF;
    r.mem_rdata  = 32'h4049_0FDB;
    retire_insn(r, r.insn, 1'b1);
    wait_drain(1'b0);
    report_test("fp");
  endtask

  task automatic overflow_drops();
    rvfi_trace_pkg::retire_t r;
    logic [rvfi_trace_pkg::DROP_W-1:0] base;
    base = drop_count;
    @(posedge clk_i);
    stall <= 1'b1;
    // Serializer holds one record, the FIFO the next TRACE_DEPTH
    for (int i = 0; i < 8; i++) begin
      r = random_retire();
      retire_insn(r, r.insn, i < rvfi_trace_pkg::TRACE_DEPTH + 1);
    end
    @(posedge clk_i);
    retire.valid <= 1'b0;
    repeat (2 * WORDS) @(posedge clk_i);
    stall <= 1'b0;
    wait_drain(1'b0);
    assert (drop_count == base + 16'd3) else begin
      $display("ERR %0t: drop_count %0d, expected %0d", $time, drop_count, base + 16'd3);
      errors++;
    end
    report_test("overflow");
  endtask

  task automatic random_mix();
    rvfi_trace_pkg::retire_t r;
    logic [rvfi_trace_pkg::DROP_W-1:0] base;
    base = drop_count;
    for (int i = 0; i < 40; i++) begin
      r = random_retire();
      retire_insn(r, r.insn, 1'b1);
      wait_drain(1'b1);
    end
    assert (drop_count == base) else begin
      $display("ERR %0t: drop_count %0d, expected %0d", $time, drop_count, base);
      errors++;
    end
    report_test("random");
  endtask

  // Words count as delivered when valid is high and stall is low
  always @(negedge clk_i) begin
    if (!reset && word_valid && !stall) begin
      assert (exp_q.size() != 0) else begin
        $display("Unexpected word at %0t (index %0d) with no record pending", $time, word_index);
        errors++;
      end
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        assert (word_index == want[34:32] && word == want[31:0]) else begin
          $display("ERR %0t: word %0d got %h at index %0d, expected %h",
                   $time, want[34:32], word, word_index, want[31:0]);
          errors++;
        end
        words_checked++;
      end
    end
  end

  initial begin
    void'($urandom(RAND_SEED));
    clk_i         = 1'b0;
    reset         = 1'b1;
    stall         = 1'b0;
    retire        = '0;
    seq_sw        = '0;
    errors        = 0;
    words_checked = 0;
    issued        = 0;
    cycles        = 0;
    repeat (4) @(posedge clk_i);
    reset <= 1'b0;
    @(posedge clk_i);
    assert (drop_count == '0) else begin
      $display("ERR %0t: drop_count %0d after reset, expected 0", $time, drop_count);
      errors++;
    end
    integer_retirements();
    memory_retirements();
    compressed_retirements();
    fp_registers();
    overflow_drops();
    random_mix();
    // Concurrent assertion failures from the bound checker
    errors += i_rvfi_trace_top.i_rvfi_trace_chk.fail_count;
    $display("Summary: %0d retirements, %0d words checked, %0d errors",
             issued, words_checked, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
